//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

    // RV32 major opcodes
    typedef logic [6:0] opcode_t;

    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_RTYPE  = 7'b0110011;
    localparam opcode_t OP_ITYPE  = 7'b0010011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    // Instruction class seen by the sequencer
    typedef enum logic [3:0] {
        CLS_ALU_R, CLS_MUL, CLS_ALU_I, CLS_JAL, CLS_JALR, CLS_BRANCH,
        CLS_LUI, CLS_AUIPC, CLS_LOAD, CLS_STORE, CLS_ILLEGAL
    } instr_class_t;

    // Immediate extender format
    typedef enum logic [2:0] {
        IMM_I = 3'd0, IMM_S = 3'd1, IMM_B = 3'd2, IMM_J = 3'd3, IMM_U = 3'd4, IMM_R = 3'd5
    } imm_src_t;

    // Synchronous exception causes (mcause encoding)
    typedef logic [31:0] cause_t;

    localparam cause_t CAUSE_ILLEGAL          = 32'd2;
    localparam cause_t CAUSE_LOAD_MISALIGNED  = 32'd4;
    localparam cause_t CAUSE_LOAD_FAULT       = 32'd5;
    localparam cause_t CAUSE_STORE_MISALIGNED = 32'd6;
    localparam cause_t CAUSE_STORE_FAULT      = 32'd7;

    // funct7 bit that selects the M extension within R-type
    localparam int MUL_FUNCT7_BIT = 0;

endpackage

//--- design/fsm_ctrl_pkg.sv
package fsm_ctrl_pkg;

    // Controller states
    typedef enum logic [4:0] {
        ST_FETCH,
        ST_DECODE,
        ST_MEM_ADDR,
        ST_MEM_READ,
        ST_MEM_WB,
        ST_MEM_WRITE,
        ST_EXEC_R,
        ST_EXEC_I,
        ST_ALU_WB,
        ST_JAL,
        ST_JALR,
        ST_BRANCH,
        ST_LUI,
        ST_AUIPC,
        ST_EXEC_MUL,
        ST_MUL_WB,
        ST_TRAP,
        ST_TRAP_PC
    } ctrl_state_t;

    // ALU operand A mux
    typedef enum logic [1:0] {
        SRCA_PC, SRCA_OLD_PC, SRCA_RS1_BUF, SRCA_ZERO
    } src_a_t;

    // ALU operand B mux
    typedef enum logic [1:0] {
        SRCB_RS2_BUF, SRCB_IMM, SRCB_CONST_4
    } src_b_t;

    // ALU decoder request
    typedef enum logic [2:0] {
        ALU_OP_ADD, ALU_OP_ARITH_LOGIC, ALU_OP_BRANCH, ALU_OP_LUI, ALU_OP_AUIPC
    } alu_op_t;

    // Result bus mux
    typedef enum logic [1:0] {
        RES_ALU_OUT, RES_ALU_RESULT, RES_MEM_DATA, RES_MUL_OUT
    } result_src_t;

    // Memory address mux
    typedef enum logic {
        ADR_PC, ADR_RESULT
    } adr_src_t;

endpackage

//--- design/dp_ctrl_if.sv
`timescale 1ns/1ps

interface dp_ctrl_if import fsm_ctrl_pkg::*; ();
    adr_src_t    adr_src;
    src_a_t      alu_src_a;
    src_b_t      alu_src_b;
    alu_op_t     alu_op;
    result_src_t result_src;
    logic        pc_update;
    logic        branch;
    logic        reg_write;
    logic        mem_write;
    logic        mem_valid;
    logic        alu_out_write;
    logic        mul_valid;

    modport encoder (output adr_src, alu_src_a, alu_src_b, alu_op, result_src, pc_update,
                     branch, reg_write, mem_write, mem_valid, alu_out_write, mul_valid);

    modport datapath (input adr_src, alu_src_a, alu_src_b, alu_op, result_src, pc_update,
                      branch, reg_write, mem_write, mem_valid, alu_out_write, mul_valid);
endinterface

//--- design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import rv_isa_pkg::*; (
    input  opcode_t      op,
    input  logic [6:0]   funct7,
    output instr_class_t instr_class,
    output imm_src_t     imm_src
);

    logic is_mul;

    // M extension shares the R-type opcode
    assign is_mul = funct7[MUL_FUNCT7_BIT];

    always_comb begin
        case (op)
            OP_RTYPE:  instr_class = is_mul ? CLS_MUL : CLS_ALU_R;
            OP_ITYPE:  instr_class = CLS_ALU_I;
            OP_JAL:    instr_class = CLS_JAL;
            OP_JALR:   instr_class = CLS_JALR;
            OP_BRANCH: instr_class = CLS_BRANCH;
            OP_LUI:    instr_class = CLS_LUI;
            OP_AUIPC:  instr_class = CLS_AUIPC;
            OP_LOAD:   instr_class = CLS_LOAD;
            OP_STORE:  instr_class = CLS_STORE;
            // fence and system opcodes land here too
            default:   instr_class = CLS_ILLEGAL;
        endcase
    end

    // Immediate format follows the class
    always_comb begin
        case (instr_class)
            CLS_ALU_I,
            CLS_JALR,
            CLS_LOAD:   imm_src = IMM_I;
            CLS_STORE:  imm_src = IMM_S;
            CLS_BRANCH: imm_src = IMM_B;
            CLS_LUI,
            CLS_AUIPC:  imm_src = IMM_U;
            CLS_JAL:    imm_src = IMM_J;
            default:    imm_src = IMM_R;
        endcase
    end

endmodule

//--- design/state_sequencer.sv
`timescale 1ns/1ps

module state_sequencer import rv_isa_pkg::*, fsm_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         resetn,
    input  instr_class_t instr_class,
    input  logic         mem_ready,
    input  logic         mul_ready,
    input  logic         access_fault,
    input  logic         unaligned_load,
    input  logic         unaligned_store,
    output ctrl_state_t  state,
    output cause_t       trap_cause
);

    ctrl_state_t next_state;
    cause_t      cause_d;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= ST_FETCH;
        end else begin
            state <= next_state;
        end
    end

    // Latch the cause on the way into the trap state
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            trap_cause <= '0;
        end else if (next_state == ST_TRAP) begin
            trap_cause <= cause_d;
        end
    end

    always_comb begin
        next_state = ST_FETCH;
        cause_d    = CAUSE_ILLEGAL;
        case (state)
            ST_FETCH:     next_state = mem_ready ? ST_DECODE : ST_FETCH;
            ST_DECODE: begin
                case (instr_class)
                    CLS_LOAD,
                    CLS_STORE:  next_state = ST_MEM_ADDR;
                    CLS_ALU_R:  next_state = ST_EXEC_R;
                    CLS_MUL:    next_state = ST_EXEC_MUL;
                    CLS_ALU_I:  next_state = ST_EXEC_I;
                    CLS_JAL:    next_state = ST_JAL;
                    CLS_JALR:   next_state = ST_JALR;
                    CLS_BRANCH: next_state = ST_BRANCH;
                    CLS_LUI:    next_state = ST_LUI;
                    CLS_AUIPC:  next_state = ST_AUIPC;
                    default:    next_state = ST_TRAP;
                endcase
            end
            ST_MEM_ADDR: begin
                // Access fault wins over misalignment
                if (instr_class == CLS_LOAD) begin
                    if (access_fault) begin
                        next_state = ST_TRAP;
                        cause_d    = CAUSE_LOAD_FAULT;
                    end else if (unaligned_load) begin
                        next_state = ST_TRAP;
                        cause_d    = CAUSE_LOAD_MISALIGNED;
                    end else begin
                        next_state = ST_MEM_READ;
                    end
                end else if (access_fault) begin
                    next_state = ST_TRAP;
                    cause_d    = CAUSE_STORE_FAULT;
                end else if (unaligned_store) begin
                    next_state = ST_TRAP;
                    cause_d    = CAUSE_STORE_MISALIGNED;
                end else begin
                    next_state = ST_MEM_WRITE;
                end
            end
            ST_MEM_READ:  next_state = mem_ready ? ST_MEM_WB : ST_MEM_READ;
            ST_MEM_WRITE: next_state = mem_ready ? ST_FETCH : ST_MEM_WRITE;
            ST_EXEC_R,
            ST_EXEC_I,
            ST_LUI,
            ST_AUIPC,
            ST_JAL:       next_state = ST_ALU_WB;
            // JALR computes the target, then shares the JAL jump cycle
            ST_JALR:      next_state = ST_JAL;
            ST_EXEC_MUL:  next_state = mul_ready ? ST_MUL_WB : ST_EXEC_MUL;
            ST_TRAP:      next_state = ST_TRAP_PC;
            default:      next_state = ST_FETCH;
        endcase
    end

endmodule

//--- design/control_encoder.sv
`timescale 1ns/1ps

module control_encoder import rv_isa_pkg::*, fsm_ctrl_pkg::*; (
    input  ctrl_state_t       state,
    input  cause_t            trap_cause,
    input  logic              mem_ready,
    input  logic              zero,
    dp_ctrl_if.encoder        ctrl,
    output logic              fetched_instr,
    output logic              instr_retired,
    output logic              exception_event,
    output cause_t            cause
);

    logic mem_req;

    // ALUOut register only loads while memory is idle
    assign ctrl.mem_valid     = mem_req;
    assign ctrl.alu_out_write = ~mem_req;

    always_comb begin
        ctrl.adr_src    = ADR_PC;
        ctrl.alu_src_a  = SRCA_PC;
        ctrl.alu_src_b  = SRCB_RS2_BUF;
        ctrl.alu_op     = ALU_OP_ADD;
        ctrl.result_src = RES_ALU_OUT;
        ctrl.pc_update  = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.mul_valid  = 1'b0;
        mem_req         = 1'b0;
        fetched_instr   = 1'b0;
        instr_retired   = 1'b0;
        exception_event = 1'b0;
        cause           = '0;

        case (state)
            ST_FETCH: begin
                // PC + 4 goes straight to the PC when the word arrives
                mem_req         = 1'b1;
                ctrl.alu_src_b  = SRCB_CONST_4;
                ctrl.result_src = RES_ALU_RESULT;
                fetched_instr   = mem_ready;
                ctrl.pc_update  = mem_ready;
            end
            ST_DECODE: begin
                // Branch target precomputed into ALUOut
                ctrl.alu_src_a = SRCA_OLD_PC;
                ctrl.alu_src_b = SRCB_IMM;
            end
            ST_MEM_ADDR,
            ST_JALR: begin
                ctrl.alu_src_a = SRCA_RS1_BUF;
                ctrl.alu_src_b = SRCB_IMM;
            end
            ST_MEM_READ: begin
                mem_req      = 1'b1;
                ctrl.adr_src = ADR_RESULT;
            end
            ST_MEM_WB: begin
                mem_req         = 1'b1;
                ctrl.result_src = RES_MEM_DATA;
                ctrl.reg_write  = 1'b1;
                instr_retired   = 1'b1;
            end
            ST_MEM_WRITE: begin
                mem_req        = 1'b1;
                ctrl.adr_src   = ADR_RESULT;
                ctrl.mem_write = 1'b1;
                instr_retired  = mem_ready;
            end
            ST_EXEC_R: begin
                ctrl.alu_src_a = SRCA_RS1_BUF;
                ctrl.alu_op    = ALU_OP_ARITH_LOGIC;
            end
            ST_EXEC_I: begin
                ctrl.alu_src_a = SRCA_RS1_BUF;
                ctrl.alu_src_b = SRCB_IMM;
                ctrl.alu_op    = ALU_OP_ARITH_LOGIC;
            end
            ST_ALU_WB: begin
                // Holds ALUOut so the write-back value stays stable
                mem_req        = 1'b1;
                ctrl.reg_write = 1'b1;
                instr_retired  = 1'b1;
            end
            ST_JAL: begin
                // Jump to ALUOut while old PC + 4 becomes the link value
                ctrl.alu_src_a = SRCA_OLD_PC;
                ctrl.alu_src_b = SRCB_CONST_4;
                ctrl.pc_update = 1'b1;
            end
            ST_BRANCH: begin
                ctrl.alu_src_a = SRCA_RS1_BUF;
                ctrl.alu_op    = ALU_OP_BRANCH;
                ctrl.branch    = 1'b1;
                mem_req        = zero;
                instr_retired  = 1'b1;
            end
            ST_LUI: begin
                ctrl.alu_src_a = SRCA_ZERO;
                ctrl.alu_src_b = SRCB_IMM;
                ctrl.alu_op    = ALU_OP_LUI;
            end
            ST_AUIPC: begin
                ctrl.alu_src_a = SRCA_OLD_PC;
                ctrl.alu_src_b = SRCB_IMM;
                ctrl.alu_op    = ALU_OP_AUIPC;
            end
            ST_EXEC_MUL: begin
                ctrl.alu_src_a = SRCA_RS1_BUF;
                ctrl.mul_valid = 1'b1;
            end
            ST_MUL_WB: begin
                mem_req         = 1'b1;
                ctrl.result_src = RES_MUL_OUT;
                ctrl.reg_write  = 1'b1;
                instr_retired   = 1'b1;
            end
            ST_TRAP: begin
                exception_event = 1'b1;
                cause           = trap_cause;
            end
            ST_TRAP_PC: begin
                // PC takes the handler address from the trap unit
                ctrl.pc_update = 1'b1;
                instr_retired  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- design/rv_main_ctrl.sv
`timescale 1ns/1ps

module rv_main_ctrl import rv_isa_pkg::*, fsm_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic [6:0]  op,
    input  logic [6:0]  funct7,
    input  logic        zero,
    input  logic        mem_ready,
    input  logic        mul_ready,
    input  logic        access_fault,
    input  logic        unaligned_load,
    input  logic        unaligned_store,
    output logic        adr_src,
    output logic [1:0]  alu_src_a,
    output logic [1:0]  alu_src_b,
    output logic [2:0]  alu_op,
    output logic [1:0]  result_src,
    output logic [2:0]  imm_src,
    output logic        pc_update,
    output logic        branch,
    output logic        reg_write,
    output logic        mem_write,
    output logic        mem_valid,
    output logic        alu_out_write,
    output logic        mul_valid,
    output logic        fetched_instr,
    output logic        instr_retired,
    output logic        exception_event,
    output logic [31:0] cause
);

    instr_class_t instr_class;
    ctrl_state_t  state;
    cause_t       trap_cause;

    dp_ctrl_if ctrl_bus ();

    instr_decoder u_decoder (
        .op          (op),
        .funct7      (funct7),
        .instr_class (instr_class),
        .imm_src     (imm_src)
    );

    state_sequencer u_sequencer (
        .clk             (clk),
        .resetn          (resetn),
        .instr_class     (instr_class),
        .mem_ready       (mem_ready),
        .mul_ready       (mul_ready),
        .access_fault    (access_fault),
        .unaligned_load  (unaligned_load),
        .unaligned_store (unaligned_store),
        .state           (state),
        .trap_cause      (trap_cause)
    );

    control_encoder u_encoder (
        .state           (state),
        .trap_cause      (trap_cause),
        .mem_ready       (mem_ready),
        .zero            (zero),
        .ctrl            (ctrl_bus),
        .fetched_instr   (fetched_instr),
        .instr_retired   (instr_retired),
        .exception_event (exception_event),
        .cause           (cause)
    );

    // Datapath side of the control bundle
    assign adr_src       = ctrl_bus.adr_src;
    assign alu_src_a     = ctrl_bus.alu_src_a;
    assign alu_src_b     = ctrl_bus.alu_src_b;
    assign alu_op        = ctrl_bus.alu_op;
    assign result_src    = ctrl_bus.result_src;
    assign pc_update     = ctrl_bus.pc_update;
    assign branch        = ctrl_bus.branch;
    assign reg_write     = ctrl_bus.reg_write;
    assign mem_write     = ctrl_bus.mem_write;
    assign mem_valid     = ctrl_bus.mem_valid;
    assign alu_out_write = ctrl_bus.alu_out_write;
    assign mul_valid     = ctrl_bus.mul_valid;

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for five rising edges
    initial begin
        resetn <= 1'b0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

//--- dv/tb_rv_main_ctrl.sv
`timescale 1ns/1ps

module tb_rv_main_ctrl import rv_isa_pkg::*, fsm_ctrl_pkg::*; ();

    localparam int NUM_LINES = 18;
    localparam int FIELDS    = 11;
    localparam int TIMEOUT   = 64;

    logic        clk;
    logic        resetn;
    logic [6:0]  op;
    logic [6:0]  funct7;
    logic        zero;
    logic        mem_ready;
    logic        mul_ready;
    logic        access_fault;
    logic        unaligned_load;
    logic        unaligned_store;
    logic        adr_src;
    logic [1:0]  alu_src_a;
    logic [1:0]  alu_src_b;
    logic [2:0]  alu_op;
    logic [1:0]  result_src;
    logic [2:0]  imm_src;
    logic        pc_update;
    logic        branch;
    logic        reg_write;
    logic        mem_write;
    logic        mem_valid;
    logic        alu_out_write;
    logic        mul_valid;
    logic        fetched_instr;
    logic        instr_retired;
    logic        exception_event;
    logic [31:0] cause;

    // Per line: six input fields, then five expected fields
    logic [31:0] test_data [NUM_LINES * FIELDS];
    int          checks = 0;
    int          errors = 0;
    int          retired_total = 0;
    int          cur_line = 0;
    bit          aborted = 1'b0;

    tb_clock_gen clk_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    rv_main_ctrl dut0 (
        .clk             (clk),
        .resetn          (resetn),
        .op              (op),
        .funct7          (funct7),
        .zero            (zero),
        .mem_ready       (mem_ready),
        .mul_ready       (mul_ready),
        .access_fault    (access_fault),
        .unaligned_load  (unaligned_load),
        .unaligned_store (unaligned_store),
        .adr_src         (adr_src),
        .alu_src_a       (alu_src_a),
        .alu_src_b       (alu_src_b),
        .alu_op          (alu_op),
        .result_src      (result_src),
        .imm_src         (imm_src),
        .pc_update       (pc_update),
        .branch          (branch),
        .reg_write       (reg_write),
        .mem_write       (mem_write),
        .mem_valid       (mem_valid),
        .alu_out_write   (alu_out_write),
        .mul_valid       (mul_valid),
        .fetched_instr   (fetched_instr),
        .instr_retired   (instr_retired),
        .exception_event (exception_event),
        .cause           (cause)
    );

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s on line %0d: got 0x%0h, expected 0x%0h",
                     name, cur_line, got, exp);
        end
    endtask

    task automatic confirm(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error on line %0d: %s", cur_line, what);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("Timeout on line %0d: %s never came within %0d cycles",
                 cur_line, what, TIMEOUT);
    endtask

    // Fetch state with no word yet
    task automatic verify_fetch_idle();
        compare_value("mem_valid", 32'(mem_valid), 32'd1);
        compare_value("pc_update", 32'(pc_update), 32'd0);
        compare_value("reg_write", 32'(reg_write), 32'd0);
        compare_value("mem_write", 32'(mem_write), 32'd0);
        compare_value("exception_event", 32'(exception_event), 32'd0);
    endtask

    // Fetch reads at the PC and forms PC + 4 for the PC
    task automatic check_fetch_selects();
        compare_value("adr_src", 32'(adr_src), 32'(ADR_PC));
        compare_value("alu_src_a", 32'(alu_src_a), 32'(SRCA_PC));
        compare_value("alu_src_b", 32'(alu_src_b), 32'(SRCB_CONST_4));
        compare_value("result_src", 32'(result_src), 32'(RES_ALU_RESULT));
    endtask

    // Cycles from fetch to retire where no handshake lies between, else 0
    function automatic int fixed_latency(input logic [6:0] opcode, input logic [6:0] f7);
        case (opcode)
            OP_RTYPE:  return f7[MUL_FUNCT7_BIT] ? 0 : 3;
            OP_ITYPE,
            OP_LUI,
            OP_AUIPC,
            OP_JAL:    return 3;
            OP_JALR:   return 4;
            OP_BRANCH: return 2;
            OP_LOAD,
            OP_STORE:  return 0;
            // Decode, trap, then trap-PC
            default:   return 3;
        endcase
    endfunction

    // Immediate format per opcode, -1 where the opcode has none
    function automatic int expected_imm(input logic [6:0] opcode);
        case (opcode)
            OP_RTYPE:  return int'(IMM_R);
            OP_ITYPE,
            OP_JALR,
            OP_LOAD:   return int'(IMM_I);
            OP_STORE:  return int'(IMM_S);
            OP_BRANCH: return int'(IMM_B);
            OP_LUI,
            OP_AUIPC:  return int'(IMM_U);
            OP_JAL:    return int'(IMM_J);
            default:   return -1;
        endcase
    endfunction

    // Source of the register file write
    function automatic result_src_t writeback_source(input logic [6:0] opcode,
                                                     input logic [6:0] f7);
        if (opcode == OP_LOAD) begin
            return RES_MEM_DATA;
        end
        if (opcode == OP_RTYPE && f7[MUL_FUNCT7_BIT]) begin
            return RES_MUL_OUT;
        end
        return RES_ALU_OUT;
    endfunction

    task automatic run_line(input int idx);
        int   base;
        int   cyc;
        int   fetch_cyc;
        int   exc_cyc;
        int   rw_cycles;
        int   mw_cycles;
        int   br_cycles;
        int   exc_cycles;
        int   mem_low;
        int   mul_low;
        int   lat;
        int   imm_exp;
        bit   fetching;
        bit   mem_armed;
        bit   mul_waiting;
        bit   store_wait;
        bit   retired;
        logic next_mem;
        logic next_mul;

        base        = idx * FIELDS;
        cur_line    = idx + 1;
        fetch_cyc   = 0;
        exc_cyc     = 0;
        rw_cycles   = 0;
        mw_cycles   = 0;
        br_cycles   = 0;
        exc_cycles  = 0;
        mul_low     = 0;
        fetching    = 1'b1;
        mem_armed   = 1'b1;
        mul_waiting = 1'b0;
        store_wait  = 1'b0;
        retired     = 1'b0;
        mem_low     = $urandom_range(3, 0);

        // Fields stay put until the line retires
        @(posedge clk);
        op              <= test_data[base][6:0];
        funct7          <= test_data[base + 1][6:0];
        zero            <= test_data[base + 2][0];
        access_fault    <= test_data[base + 3][0];
        unaligned_load  <= test_data[base + 4][0];
        unaligned_store <= test_data[base + 5][0];
        mem_ready       <= (mem_low == 0);
        mul_ready       <= 1'b0;

        for (cyc = 1; cyc <= TIMEOUT && !retired; cyc++) begin
            @(negedge clk);
            next_mem = mem_ready;
            next_mul = mul_ready;

            // Memory wait is the fetch, or a data access at the result address
            if (fetching || (mem_valid && adr_src)) begin
                if (mem_ready) begin
                    next_mem  = 1'b0;
                    mem_armed = 1'b0;
                end else if (!mem_armed) begin
                    mem_armed = 1'b1;
                    mem_low   = $urandom_range(3, 0);
                    next_mem  = (mem_low == 0);
                end else begin
                    mem_low  = mem_low - 1;
                    next_mem = (mem_low == 0);
                end
            end

            if (mul_waiting) begin
                confirm(mul_valid, "mul_valid fell before mul_ready was driven");
            end
            if (mul_valid && mul_ready) begin
                next_mul    = 1'b0;
                mul_waiting = 1'b0;
            end else if (mul_valid && !mul_waiting) begin
                mul_waiting = 1'b1;
                mul_low     = $urandom_range(3, 0);
                next_mul    = (mul_low == 0);
            end else if (mul_valid) begin
                mul_low  = mul_low - 1;
                next_mul = (mul_low == 0);
            end else begin
                mul_waiting = 1'b0;
            end

            // ALUOut loads only while memory is idle
            compare_value("alu_out_write", 32'(alu_out_write), 32'(!mem_valid));

            if (fetched_instr) begin
                confirm(fetching, "fetched_instr pulsed a second time for one line");
                confirm(mem_ready && pc_update, "fetched_instr without mem_ready and pc_update");
                check_fetch_selects();
                imm_exp = expected_imm(test_data[base][6:0]);
                if (imm_exp >= 0) begin
                    compare_value("imm_src", 32'(imm_src), 32'(imm_exp));
                end
                fetching  = 1'b0;
                fetch_cyc = cyc;
            end else if (fetching) begin
                verify_fetch_idle();
                check_fetch_selects();
            end

            if (reg_write) begin
                rw_cycles++;
                compare_value("result_src", 32'(result_src),
                              32'(writeback_source(test_data[base][6:0],
                                                   test_data[base + 1][6:0])));
            end
            if (store_wait) begin
                confirm(mem_write, "mem_write fell before mem_ready");
            end
            if (mem_write) begin
                mw_cycles++;
                store_wait = 1'b1;
                compare_value("adr_src", 32'(adr_src), 32'(ADR_RESULT));
            end
            if (branch) begin
                br_cycles++;
                compare_value("mem_valid", 32'(mem_valid), 32'(test_data[base + 2][0]));
                compare_value("alu_op", 32'(alu_op), 32'(ALU_OP_BRANCH));
                compare_value("alu_src_a", 32'(alu_src_a), 32'(SRCA_RS1_BUF));
                compare_value("alu_src_b", 32'(alu_src_b), 32'(SRCB_RS2_BUF));
                confirm(instr_retired, "branch cycle without instr_retired");
            end
            if (exception_event) begin
                exc_cycles++;
                exc_cyc = cyc;
                compare_value("cause", cause, test_data[base + 10]);
            end else begin
                compare_value("cause", cause, 32'd0);
            end

            if (instr_retired) begin
                retired = 1'b1;
                confirm(!fetching, "instr_retired before the fetch completed");
                if (mem_write) begin
                    confirm(mem_ready, "store retired without mem_ready");
                end
                if (test_data[base + 9][0]) begin
                    confirm(pc_update, "trap retired without pc_update");
                    confirm(exc_cyc == cyc - 1, "retire did not follow the exception cycle");
                end
                lat = fixed_latency(test_data[base][6:0], test_data[base + 1][6:0]);
                if (lat > 0) begin
                    compare_value("instr_retired delay", 32'(cyc - fetch_cyc), 32'(lat));
                end
            end else begin
                @(posedge clk);
                mem_ready <= next_mem;
                mul_ready <= next_mul;
            end
        end

        if (!retired) begin
            if (fetching) begin
                report_timeout("fetched_instr");
            end else if (mul_waiting) begin
                report_timeout("mul handshake");
            end else if (mem_armed) begin
                report_timeout("memory handshake");
            end else begin
                report_timeout("instr_retired");
            end
        end else begin
            compare_value("reg_write cycles", 32'(rw_cycles), test_data[base + 6]);
            compare_value("mem_write seen", 32'(mw_cycles != 0), test_data[base + 7]);
            compare_value("branch cycles", 32'(br_cycles), test_data[base + 8]);
            compare_value("exception_event cycles", 32'(exc_cycles), test_data[base + 9]);
        end
    endtask

    always @(negedge clk) begin
        if (resetn === 1'b1 && instr_retired === 1'b1) begin
            retired_total <= retired_total + 1;
        end
    end

    initial begin
        int n;

        void'($urandom(72));
        op              <= '0;
        funct7          <= '0;
        zero            <= 1'b0;
        mem_ready       <= 1'b0;
        mul_ready       <= 1'b0;
        access_fault    <= 1'b0;
        unaligned_load  <= 1'b0;
        unaligned_store <= 1'b0;
        $readmemh("dv/ctrl_testdata.txt", test_data);

        // Controller sits in fetch through reset
        n = 0;
        do begin
            @(negedge clk);
            verify_fetch_idle();
            n++;
        end while (resetn !== 1'b1 && n < TIMEOUT);
        if (resetn !== 1'b1) begin
            report_timeout("reset release");
        end

        for (n = 0; n < NUM_LINES && !aborted; n++) begin
            run_line(n);
        end

        @(posedge clk);
        mem_ready <= 1'b0;
        mul_ready <= 1'b0;
        // Idle cycles so that a stray retire is counted
        repeat (4) @(negedge clk);
        compare_value("instr_retired pulses", 32'(retired_total), 32'(NUM_LINES));

        $display("checks %0d, errors %0d, lines run %0d of %0d",
                 checks, errors, cur_line, NUM_LINES);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- rv_main_ctrl.f
design/rv_isa_pkg.sv
design/fsm_ctrl_pkg.sv
design/dp_ctrl_if.sv
design/instr_decoder.sv
design/state_sequencer.sv
design/control_encoder.sv
design/rv_main_ctrl.sv
dv/tb_clock_gen.sv
dv/tb_rv_main_ctrl.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_main_ctrl -f rv_main_ctrl.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
exit 0

//--- dv/ctrl_testdata.txt
// op funct7 zero access_fault unaligned_load unaligned_store, then expected
// reg_write cycles, mem_write seen, branch cycles, exception cycles, cause
33 20 0 0 0 0 1 0 0 0 0
33 01 0 0 0 0 1 0 0 0 0
13 00 0 0 0 0 1 0 0 0 0
37 00 0 0 0 0 1 0 0 0 0
17 00 0 0 0 0 1 0 0 0 0
6f 00 0 0 0 0 1 0 0 0 0
67 00 0 0 0 0 1 0 0 0 0
63 00 1 0 0 0 0 0 1 0 0
63 00 0 0 0 0 0 0 1 0 0
03 00 0 0 0 0 1 0 0 0 0
23 00 0 0 0 0 0 1 0 0 0
03 00 0 0 1 0 0 0 0 1 4
03 00 0 1 1 0 0 0 0 1 5
23 00 0 0 0 1 0 0 0 1 6
23 00 0 1 0 1 0 0 0 1 7
0f 00 0 0 0 0 0 0 0 1 2
73 00 0 0 0 0 0 0 0 1 2
03 00 0 0 0 1 1 0 0 0 0
